/* common/vic_pkg.sv */
package vic_pkg;

  typedef logic [3:0] color_t;     // palette index
  typedef logic [5:0] chan_t;      // one video channel level
  typedef logic [5:0] reg_addr_t;  // register address off adl
  typedef logic [7:0] data_t;      // cpu data byte
  typedef logic [8:0] line_t;      // raster line number
  typedef logic [9:0] dot_t;       // dot position in a line

  // register map, only the subset this model decodes
  localparam reg_addr_t reg_ctrl1    = 6'h11; // bit 7 is raster bit 8
  localparam reg_addr_t reg_raster   = 6'h12; // raster low byte
  localparam reg_addr_t reg_irq_stat = 6'h19; // bit 0 raster, bit 7 any
  localparam reg_addr_t reg_irq_en   = 6'h1a; // bit 0 enables raster irq
  localparam reg_addr_t reg_border   = 6'h20;
  localparam reg_addr_t reg_bg       = 6'h21;

  // cpu side bus fsm
  typedef enum logic [1:0] {
    idle,
    cpu_read,
    cpu_write
  } bus_state_t;

  // classic 16 colour palette, one row per index, columns are red green blue
  localparam chan_t palette_rgb [16][3] = '{
    '{6'h00, 6'h00, 6'h00},  // black
    '{6'h3f, 6'h3f, 6'h3f},  // white
    '{6'h2b, 6'h0a, 6'h0a},  // red
    '{6'h18, 6'h36, 6'h33},  // cyan
    '{6'h2c, 6'h0f, 6'h2d},  // purple
    '{6'h13, 6'h33, 6'h0d},  // green
    '{6'h0d, 6'h0e, 6'h31},  // blue
    '{6'h3f, 6'h3f, 6'h15},  // yellow
    '{6'h2c, 6'h19, 6'h06},  // orange
    '{6'h1a, 6'h10, 6'h00},  // brown
    '{6'h3a, 6'h1c, 6'h1c},  // light red
    '{6'h13, 6'h13, 6'h13},  // dark grey
    '{6'h22, 6'h22, 6'h22},  // mid grey
    '{6'h2c, 6'h3f, 6'h29},  // light green
    '{6'h1b, 6'h1c, 6'h3f},  // light blue
    '{6'h2e, 6'h2e, 6'h2e}   // light grey
  };

  // colour regs read back with the unused upper nibble high
  localparam logic [3:0] color_pad = 4'hf;

  // value returned for anything not decoded
  localparam data_t unmapped_data = 8'hff;

endpackage : vic_pkg

/* rtl/phase_gen.sv */
module phase_gen (
  input  logic clk_col4x_pal,
  input  logic rst,
  output logic dot_en,   // one clock in four
  output logic clk_phi,  // cpu phi clock, 16 low then 16 high
  output logic phi_end   // last clock of the phi high half
);

  // one phi cycle is 32 master clocks, i.e. 8 dots
  logic [4:0] phase;

  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      phase <= '0;
    end else begin
      phase <= phase + 5'd1; // free running, wraps every phi cycle
    end
  end

  // all three decode straight off the counter
  // phase is 0 in reset so everything sits low there
  assign dot_en  = (phase[1:0] == 2'b11);  // first one on the 4th clock out of reset
  assign clk_phi = phase[4];               // upper half of the cycle
  assign phi_end = (phase == 5'd31);       // also lands on a dot_en

  // end of the high half must drop phi on the next clock
  // and must coincide with a dot strobe so bus writes line up with pixels
  phi_end_in_high: assert property (
    @(posedge clk_col4x_pal) disable iff (rst)
    phi_end |-> clk_phi && dot_en ##1 !clk_phi
  ) else $error("phi_end outside the phi high half");

endmodule : phase_gen

/* bus/bus_regs.sv */
module bus_regs
  import vic_pkg::*;
(
  input  logic      clk_col4x_pal,
  input  logic      rst,
  input  logic      clk_phi,
  input  logic      phi_end,
  input  logic      ce,            // low selects the chip
  input  logic      rw,            // high read, low write
  input  reg_addr_t adl,
  input  data_t     data_in,       // dbl as seen from the pins
  input  line_t     line,          // current raster line
  input  logic      raster_hit,
  output line_t     raster_cmp,
  output color_t    border_color,
  output color_t    bg_color,
  output data_t     data_out,
  output logic      drive_db,
  output logic      irq            // active low
);

  bus_state_t state;

  logic       clk_phi_d;    // phi one clock ago, for the rising edge
  logic       phi_first;    // first clock of the phi high half
  logic       decode;       // access starts this clock
  reg_addr_t  addr_q;       // address held for the write at phi_end
  logic [6:0] ctrl1_low;    // ctrl1 bits 6..0, readback only here
  data_t      irq_en;       // full byte kept, bit 0 is raster enable
  logic       raster_stat;  // raster status, write one to clear
  logic       irq_any;      // any enabled source pending
  logic       wr_stb;       // write lands this clock
  data_t      rd_data;      // read mux

  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      clk_phi_d <= 1'b0;
    end else begin
      clk_phi_d <= clk_phi;
    end
  end

  assign phi_first = clk_phi && !clk_phi_d;
  // ce has to be low on the first high clock, a late ce waits for the next half
  assign decode    = phi_first && !ce && (state == idle);

  // bus fsm
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (decode) begin
            state <= rw ? cpu_read : cpu_write;
          end
        end
        cpu_read, cpu_write: begin
          if (phi_end) begin
            state <= idle; // access ends with the phi high half
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // address held from decode, data sampled at phi_end
  always_ff @(posedge clk_col4x_pal) begin
    if (decode) begin
      addr_q <= adl;
    end
  end

  assign wr_stb = (state == cpu_write) && phi_end;

  // register file
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      raster_cmp   <= '0;
      ctrl1_low    <= '0;
      irq_en       <= '0;
      border_color <= 4'd14; // light blue
      bg_color     <= 4'd6;  // blue
    end else if (wr_stb) begin
      case (addr_q)
        reg_raster: raster_cmp[7:0] <= data_in;
        reg_ctrl1: begin
          raster_cmp[8] <= data_in[7]; // raster bit 8 lives in ctrl1
          ctrl1_low     <= data_in[6:0];
        end
        reg_irq_en: irq_en       <= data_in;
        reg_border: border_color <= data_in[3:0];
        reg_bg:     bg_color     <= data_in[3:0];
        default: ; // writes elsewhere are dropped
      endcase
    end
  end

  // raster status, a new hit wins over a clear in the same clock
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      raster_stat <= 1'b0;
    end else if (raster_hit) begin
      raster_stat <= 1'b1;
    end else if (wr_stb && (addr_q == reg_irq_stat) && data_in[0]) begin
      raster_stat <= 1'b0;
    end
  end

  assign irq_any = raster_stat && irq_en[0];
  assign irq     = !irq_any; // open collector style, low when pending

  // read mux, raster regs give the live line not the compare value
  always_comb begin
    case (adl)
      reg_raster:   rd_data = line[7:0];
      reg_ctrl1:    rd_data = {line[8], ctrl1_low};
      reg_irq_stat: rd_data = {irq_any, 3'b111, 3'b000, raster_stat};
      reg_irq_en:   rd_data = irq_en;
      reg_border:   rd_data = {color_pad, border_color};
      reg_bg:       rd_data = {color_pad, bg_color};
      default:      rd_data = unmapped_data;
    endcase
  end

  // read data captured once at decode and held through the access
  always_ff @(posedge clk_col4x_pal) begin
    if (decode && rw) begin
      data_out <= rd_data;
    end
  end

  // second clock of phi high through phi_end
  assign drive_db = (state == cpu_read);

  // the pins must never fight a cpu write or drive outside phi high
  db_not_on_write: assert property (
    @(posedge clk_col4x_pal) disable iff (rst)
    drive_db |-> rw
  ) else $error("data bus driven during a cpu write");

  db_only_phi_high: assert property (
    @(posedge clk_col4x_pal) disable iff (rst)
    drive_db |-> clk_phi
  ) else $error("data bus driven while phi low");

endmodule : bus_regs

/* raster/raster_timing.sv */
module raster_timing
  import vic_pkg::*;
#(
  parameter int dots_per_line   = 504, // multiple of 8, at least 32
  parameter int lines_per_frame = 312  // multiple of 8, at least 8
) (
  input  logic  clk_col4x_pal,
  input  logic  rst,
  input  logic  dot_en,
  input  line_t raster_cmp,
  output dot_t  xpos,
  output line_t line,
  output logic  window,      // display window, background area
  output logic  hsync,
  output logic  vsync,
  output logic  active,      // outside both syncs
  output logic  raster_hit   // one clock pulse on stepping onto the compare line
);

  localparam dot_t  last_dot    = dot_t'(dots_per_line - 1);
  localparam line_t last_line   = line_t'(lines_per_frame - 1);
  localparam dot_t  hsync_dots  = dot_t'(8);    // dots 0..7
  localparam line_t vsync_lines = line_t'(2);   // lines 0 and 1
  localparam dot_t  win_x_first = dot_t'(16);
  localparam dot_t  win_x_last  = dot_t'(dots_per_line - 9);
  localparam line_t win_y_first = line_t'(4);
  localparam line_t win_y_last  = line_t'(lines_per_frame - 3);

  line_t next_line;
  logic  line_end; // last dot of the line

  assign line_end  = (xpos == last_dot);
  assign next_line = (line == last_line) ? '0 : line + 1'b1;

  // reset parks on the last dot of the frame
  // so the first dot_en out of reset counts dot 0 of line 0
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      xpos       <= last_dot;
      line       <= last_line;
      raster_hit <= 1'b0;
    end else begin
      raster_hit <= 1'b0;
      if (dot_en) begin
        if (line_end) begin
          xpos       <= '0;
          line       <= next_line;
          raster_hit <= (next_line == raster_cmp); // out of frame values never match
        end else begin
          xpos <= xpos + 1'b1;
        end
      end
    end
  end

  // levels straight from the counters
  assign hsync  = (xpos < hsync_dots);
  assign vsync  = (line < vsync_lines);
  assign active = !hsync && !vsync;

  assign window = (xpos >= win_x_first) && (xpos <= win_x_last) &&
                  (line >= win_y_first) && (line <= win_y_last);

  // counters stay inside the configured raster
  counters_in_range: assert property (
    @(posedge clk_col4x_pal) disable iff (rst)
    (xpos <= last_dot) && (line <= last_line)
  ) else $error("raster counters out of range");

endmodule : raster_timing

/* video/pixel_out.sv */
module pixel_out
  import vic_pkg::*;
(
  input  logic   clk_col4x_pal,
  input  logic   rst,
  input  logic   dot_en,
  input  logic   window,        // for the dot being counted now
  input  logic   active,
  input  color_t border_color,
  input  color_t bg_color,
  output chan_t  red,
  output chan_t  green,
  output chan_t  blue
);

  // column order in the palette table
  localparam int ch_red   = 0;
  localparam int ch_green = 1;
  localparam int ch_blue  = 2;

  color_t pix_color;
  chan_t  lut_red;
  chan_t  lut_green;
  chan_t  lut_blue;

  // background inside the window, border everywhere else
  assign pix_color = window ? bg_color : border_color;

  // palette lookup, small enough to sit in luts
  assign lut_red   = palette_rgb[pix_color][ch_red];
  assign lut_green = palette_rgb[pix_color][ch_green];
  assign lut_blue  = palette_rgb[pix_color][ch_blue];

  // one dot of latency, output shows the dot counted one strobe ago
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else if (dot_en) begin
      if (active) begin
        red   <= lut_red;
        green <= lut_green;
        blue  <= lut_blue;
      end else begin
        red   <= '0; // blank during sync
        green <= '0;
        blue  <= '0;
      end
    end
  end

endmodule : pixel_out

/* rtl/vic_top.sv */
module vic_top
  import vic_pkg::*;
#(
  parameter int dots_per_line   = 504, // 63 phi cycles of 8 dots
  parameter int lines_per_frame = 312
) (
  input  logic      clk_col4x_pal,
  input  logic      rst,
  input  reg_addr_t adl,     // register address from the cpu
  inout  wire data_t dbl,    // shared data bus
  input  logic      ce,      // chip enable, low active
  input  logic      rw,      // high read, low write
  output logic      irq,     // low active
  output logic      clk_phi, // phi clock out to the cpu
  output logic      hsync,
  output logic      vsync,
  output logic      active,
  output chan_t     red,
  output chan_t     green,
  output chan_t     blue
);

  logic   dot_en;
  logic   phi_end;
  dot_t   xpos;
  line_t  line;
  logic   window;
  logic   raster_hit;
  line_t  raster_cmp;
  color_t border_color;
  color_t bg_color;
  data_t  data_out;
  logic   drive_db;

  // timing base
  phase_gen u_phase_gen (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .dot_en        (dot_en),
    .clk_phi       (clk_phi),
    .phi_end       (phi_end)
  );

  raster_timing #(
    .dots_per_line   (dots_per_line),
    .lines_per_frame (lines_per_frame)
  ) u_raster_timing (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .dot_en        (dot_en),
    .raster_cmp    (raster_cmp),
    .xpos          (xpos),
    .line          (line),
    .window        (window),
    .hsync         (hsync),
    .vsync         (vsync),
    .active        (active),
    .raster_hit    (raster_hit)
  );

  // cpu side, reads whatever is on dbl
  bus_regs u_bus_regs (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .clk_phi       (clk_phi),
    .phi_end       (phi_end),
    .ce            (ce),
    .rw            (rw),
    .adl           (adl),
    .data_in       (dbl),
    .line          (line),
    .raster_hit    (raster_hit),
    .raster_cmp    (raster_cmp),
    .border_color  (border_color),
    .bg_color      (bg_color),
    .data_out      (data_out),
    .drive_db      (drive_db),
    .irq           (irq)
  );

  pixel_out u_pixel_out (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .dot_en        (dot_en),
    .window        (window),
    .active        (active),
    .border_color  (border_color),
    .bg_color      (bg_color),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

  // only drive the pins while the cpu is reading us
  assign dbl = drive_db ? data_out : 'z;

endmodule : vic_top

/* verif/tb_vic_tests.svh */
`ifndef TB_VIC_TESTS_SVH
`define TB_VIC_TESTS_SVH

// one clock on, sampled where the inputs are driven
task automatic step();
  @(posedge clk_col4x_pal);
  #5;
endtask

task automatic compare(input logic [31:0] actual, input logic [31:0] expected, input string what);
  checks++;
  assert (actual === expected) else begin
    errors++;
    $display("FAILED at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
  end
endtask

task automatic report_test(input string name, input int errors_before);
  tests_run++;
  if (errors == errors_before) begin
    $display("%s: ok", name);
  end else begin
    $display("%s: %0d errors", name, errors - errors_before);
  end
endtask

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// global dot in the raster after clock n, -1 is the dot parked in reset
function automatic int dot_at(input int n);
  return n / 4 - 1;
endfunction

function automatic int x_of(input int g);
  return (g + frame_dots) % dots;
endfunction

function automatic int y_of(input int g);
  return ((g + frame_dots) / dots) % lines;
endfunction

// red green blue packed 6 bits each
function automatic logic [17:0] palette_entry(input color_t c);
  case (c)
    4'd0:  return {6'h00, 6'h00, 6'h00}; // black
    4'd1:  return {6'h3f, 6'h3f, 6'h3f}; // white
    4'd2:  return {6'h2b, 6'h0a, 6'h0a};
    4'd3:  return {6'h18, 6'h36, 6'h33};
    4'd4:  return {6'h2c, 6'h0f, 6'h2d};
    4'd5:  return {6'h13, 6'h33, 6'h0d};
    4'd6:  return {6'h0d, 6'h0e, 6'h31};
    4'd7:  return {6'h3f, 6'h3f, 6'h15};
    4'd8:  return {6'h2c, 6'h19, 6'h06};
    4'd9:  return {6'h1a, 6'h10, 6'h00};
    4'd10: return {6'h3a, 6'h1c, 6'h1c};
    4'd11: return {6'h13, 6'h13, 6'h13};
    4'd12: return {6'h22, 6'h22, 6'h22};
    4'd13: return {6'h2c, 6'h3f, 6'h29};
    4'd14: return {6'h1b, 6'h1c, 6'h3f};
    default: return {6'h2e, 6'h2e, 6'h2e}; // light grey
  endcase
endfunction

function automatic logic [17:0] expected_rgb(input int g, input color_t border, input color_t bg);
  int   x;
  int   y;
  logic win;
  x   = x_of(g);
  y   = y_of(g);
  win = (x >= 16) && (x <= dots - 9) && (y >= 4) && (y <= lines - 3);
  if (x < 8 || y < 2) begin
    return '0; // blank in either sync
  end
  return palette_entry(win ? bg : border);
endfunction

task automatic reset_state();
  int e0;
  e0 = errors;
  repeat (8) begin
    step();
    compare(irq, 1'b1, "irq in reset");
    compare(dbl, 8'hzz, "dbl in reset");
    compare({red, green, blue}, '0, "rgb in reset");
  end
  rst = 1'b0;
  for (int n = 1; n <= 4; n++) begin
    step();
    compare(hsync, n == 4, $sformatf("hsync %0d clocks after reset", n)); // first dot on clock 4
    if (n < 4) begin
      compare(irq, 1'b1, "irq after reset");
      compare(dbl, 8'hzz, "dbl after reset");
      compare({red, green, blue}, '0, "rgb after reset");
    end
  end
  report_test("reset state", e0);
endtask

task automatic sync_timing();
  int   e0;
  int   t0;
  int   rise_at;
  int   g;
  logic prev_vs;
  e0      = errors;
  rise_at = -1;
  prev_vs = vsync;
  step();
  while (!(vsync && !prev_vs)) begin // line up on a frame start
    prev_vs = vsync;
    step();
  end
  t0 = clk_count;
  for (int i = 0; i < frame_clks; i++) begin
    prev_vs = vsync;
    step();
    g = dot_at(clk_count);
    compare(hsync, x_of(g) < 8, $sformatf("hsync line %0d dot %0d", y_of(g), x_of(g)));
    compare(vsync, y_of(g) < 2, $sformatf("vsync line %0d dot %0d", y_of(g), x_of(g)));
    compare(active, x_of(g) >= 8 && y_of(g) >= 2, $sformatf("active line %0d", y_of(g)));
    // phi low for the first 16 clocks of each 32 clock cycle out of reset
    compare(clk_phi, (clk_count % 32) >= 16, $sformatf("clk_phi clock %0d", clk_count));
    if (vsync && !prev_vs) begin
      rise_at = clk_count;
    end
  end
  compare(rise_at - t0, frame_clks, "frame period in clocks");
  report_test("sync and blanking", e0);
endtask

task automatic register_access();
  int    e0;
  data_t rd;
  e0 = errors;
  cpu_write(reg_border, 8'h05);
  cpu_write(reg_bg, 8'h0a);
  cpu_write(reg_irq_en, 8'h5a); // bit 0 low keeps the raster irq off
  cpu_read(reg_border, rd);
  compare(rd, 8'hf5, "border readback");
  cpu_read(reg_bg, rd);
  compare(rd, 8'hfa, "background readback");
  cpu_read(reg_irq_en, rd);
  compare(rd, 8'h5a, "irq enable readback");
  cpu_read(6'h3f, rd);
  compare(rd, 8'hff, "unmapped address");
  repeat (10) begin // spans more than one line
    cpu_read(reg_raster, rd);
    compare(rd, y_of(dot_at(phi_rise_count)), "raster line readback");
  end
  report_test("register access", e0);
endtask

task automatic colour_output();
  int          e0;
  logic [31:0] r;
  color_t      border;
  color_t      bg;
  e0     = errors;
  r      = lcg_next();
  border = r[27:24];
  r      = lcg_next();
  bg     = r[27:24];
  if (bg == border) begin
    bg = border + 4'd1; // window and border must differ
  end
  cpu_write(reg_bg, {4'h0, bg});
  cpu_write(reg_border, {4'h0, border});
  repeat (4) step(); // second dot strobe after phi_end
  for (int i = 0; i < frame_clks; i++) begin
    compare({red, green, blue}, expected_rgb(dot_at(clk_count) - 1, border, bg),
            $sformatf("rgb line %0d dot %0d", y_of(dot_at(clk_count) - 1),
                      x_of(dot_at(clk_count) - 1)));
    step();
  end
  report_test("colour output", e0);
endtask

task automatic raster_interrupt();
  int    e0;
  int    c;
  data_t rd;
  e0 = errors;
  cpu_write(reg_irq_en, 8'h00);
  cpu_write(reg_raster, 8'd6);
  cpu_write(reg_irq_stat, 8'h01);
  repeat (frame_clks + 64) begin // status sets, irq must not
    step();
    compare(irq, 1'b1, "irq with raster irq disabled");
  end
  cpu_read(reg_irq_stat, rd);
  compare(rd, 8'h71, "status with irq disabled");
  while (y_of(dot_at(clk_count)) != 8) begin // well clear of line 6
    step();
  end
  cpu_write(reg_irq_stat, 8'h01);
  cpu_write(reg_irq_en, 8'h01);
  cpu_read(reg_irq_stat, rd);
  compare(rd, 8'h70, "status after clear");
  c = 0;
  while (irq === 1'b1 && c < frame_clks) begin
    step();
    c++;
  end
  compare(irq, 1'b0, "irq at compare line");
  compare(dot_at(clk_count - 1) % frame_dots, 6 * dots, "irq not at start of line 6");
  compare((clk_count - 1) % 4, 0, "raster hit off the dot strobe");
  cpu_read(reg_irq_stat, rd);
  compare(rd, 8'hf1, "status with irq pending");
  cpu_write(reg_irq_stat, 8'h01);
  compare(irq, 1'b1, "irq after status clear");
  report_test("raster interrupt", e0);
endtask

`endif

/* verif/tb_vic.sv */
module tb_vic
  import vic_pkg::*;
();

  localparam int dots         = 64;                  // dots per line in this run
  localparam int lines        = 16;                  // lines per frame in this run
  localparam int frame_dots   = dots * lines;
  localparam int frame_clks   = frame_dots * 4;      // four master clocks per dot
  localparam int num_tests    = 5;
  localparam int timeout_clks = 3 * frame_clks * num_tests + 2000; // three frames a test

  logic        clk_col4x_pal;
  logic        rst;
  reg_addr_t   adl;
  logic        ce;
  logic        rw;
  data_t       dbl_drv;          // value the cpu puts on the bus
  logic        dbl_oe;           // cpu side drive enable
  wire [7:0]   dbl;
  logic        irq;
  logic        clk_phi;
  logic        hsync;
  logic        vsync;
  logic        active;
  chan_t       red;
  chan_t       green;
  chan_t       blue;

  int          clk_count;        // clocks since reset release
  int          phi_rise_count;   // clk_count when the last access started
  int          cycle_total;      // every clock, for the timeout
  int          errors;
  int          checks;
  int          tests_run;
  logic [31:0] lcg_state;

  assign dbl = dbl_oe ? dbl_drv : 'z;

  vic_top #(
    .dots_per_line   (dots),
    .lines_per_frame (lines)
  ) u_dut (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .adl           (adl),
    .dbl           (dbl),
    .ce            (ce),
    .rw            (rw),
    .irq           (irq),
    .clk_phi       (clk_phi),
    .hsync         (hsync),
    .vsync         (vsync),
    .active        (active),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

  initial begin
    clk_col4x_pal = 1'b0;
    forever #20 clk_col4x_pal = ~clk_col4x_pal;
  end

  // own dot clock reference, n after the n-th edge out of reset
  always @(posedge clk_col4x_pal) begin
    if (rst) begin
      clk_count <= 0;
    end else begin
      clk_count <= clk_count + 1;
    end
  end

  always @(posedge clk_col4x_pal) begin
    cycle_total <= cycle_total + 1;
    if (cycle_total >= timeout_clks) begin
      $display("timeout after %0d clocks, a test never finished", cycle_total);
      $display("Testbench failed");
      $finish;
    end
  end

  // write cycle, address and data go out as phi rises and hold through phi_end
  task automatic cpu_write(input reg_addr_t addr, input data_t data);
    @(posedge clk_phi);
    #5;
    ce      = 1'b0;
    rw      = 1'b0;
    adl     = addr;
    dbl_drv = data;
    dbl_oe  = 1'b1;
    @(negedge clk_phi); // phi_end edge has taken the data
    #5;
    ce     = 1'b1;
    rw     = 1'b1;
    dbl_oe = 1'b0;
  endtask

  task automatic cpu_read(input reg_addr_t addr, output data_t data);
    @(posedge clk_phi);
    #5;
    phi_rise_count = clk_count; // decode sees the line as it is now
    ce  = 1'b0;
    rw  = 1'b1;
    adl = addr;
    repeat (15) @(posedge clk_col4x_pal); // up to the phi_end clock
    @(negedge clk_col4x_pal);
    data = dbl;
    @(negedge clk_phi);
    #5;
    ce = 1'b1;
  endtask

  `include "tb_vic_tests.svh"

  initial begin
    rst         = 1'b1;
    ce          = 1'b1;
    rw          = 1'b1;
    adl         = '0;
    dbl_drv     = '0;
    dbl_oe      = 1'b0;
    errors      = 0;
    checks      = 0;
    tests_run   = 0;
    cycle_total = 0;
    lcg_state   = 32'd71205;
    reset_state();
    sync_timing();
    register_access();
    colour_output();
    raster_interrupt();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_vic

/* verilog.f */
+incdir+verif
common/vic_pkg.sv
rtl/phase_gen.sv
bus/bus_regs.sv
raster/raster_timing.sv
video/pixel_out.sv
rtl/vic_top.sv
verif/tb_vic.sv
